/* Makefile */
VERILATOR = verilator
VFLAGS    = -sv --timing --assert
TOP       = ray_hit_pos_tb
FILELIST  = ray_hit_pos.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* ray_hit_pos.f */
+incdir+testbench
source/ray_pkg.sv
source/pcalc_ctrl_if.sv
source/fp_mul.sv
source/fp_add.sv
source/data_delay.sv
source/pcalc.sv
source/pcalc_ctrl.sv
source/ray_hit_pos.sv
testbench/ray_hit_pos_tb.sv

/* source/data_delay.sv */
// Register delay line for one float word, depth set by parameter.

`timescale 1ns/1ps

module data_delay import ray_pkg::*; #(
	parameter int DEPTH = 1
) (
	input  logic   clk,
	input  logic   rst_n,
	input  float_t data_in,
	output float_t data_out
);

	float_t stage_q [DEPTH];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= data_in;
			for (int i = 1; i < DEPTH; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	assign data_out = stage_q[DEPTH-1];

endmodule : data_delay

/* source/fp_add.sv */
// Three-stage single precision adder: align, add, normalize with truncation.

`timescale 1ns/1ps

module fp_add import ray_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  float_t a,
	input  float_t b,
	output float_t result
);

	function automatic logic [4:0] lead_zeros(input logic [24:0] v);
		logic [4:0] n;
		logic       found;
		n     = 5'd25;
		found = 1'b0;
		for (int i = 24; i >= 0; i--) begin
			if (v[i] && !found) begin
				n     = 5'(24 - i);
				found = 1'b1;
			end
		end
		return n;
	endfunction

	logic        a_big;
	float_t      big;
	float_t      small_op;
	logic [23:0] big_sig;
	logic [23:0] small_sig;
	logic [7:0]  exp_diff;

	logic        s1_sign;
	logic        s1_sub;
	logic [7:0]  s1_exp;
	logic [23:0] s1_big;
	logic [23:0] s1_small;

	logic        s2_sign;
	logic [7:0]  s2_exp;
	logic [24:0] s2_sum;

	logic [4:0]        lz;
	logic [24:0]       norm;
	logic signed [9:0] exp_n;

	// Order by magnitude so the subtraction never goes negative.
	assign a_big     = {a.exp, a.frac} >= {b.exp, b.frac};
	assign big       = a_big ? a : b;
	assign small_op  = a_big ? b : a;
	assign big_sig   = (big.exp == 8'd0) ? 24'd0 : {1'b1, big.frac};
	assign small_sig = (small_op.exp == 8'd0) ? 24'd0 : {1'b1, small_op.frac};
	assign exp_diff  = big.exp - small_op.exp;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_sign  <= 1'b0;
			s1_sub   <= 1'b0;
			s1_exp   <= '0;
			s1_big   <= '0;
			s1_small <= '0;
		end else begin
			s1_sign  <= big.sign;
			s1_sub   <= a.sign ^ b.sign;
			s1_exp   <= big.exp;
			s1_big   <= big_sig;
			s1_small <= small_sig >> exp_diff; // Shifted-out bits dropped.
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s2_sign <= 1'b0;
			s2_exp  <= '0;
			s2_sum  <= '0;
		end else begin
			s2_sign <= s1_sign;
			s2_exp  <= s1_exp;
			s2_sum  <= s1_sub ? {1'b0, s1_big} - {1'b0, s1_small}
			                  : {1'b0, s1_big} + {1'b0, s1_small};
		end
	end

	assign lz    = lead_zeros(s2_sum);
	assign norm  = s2_sum << lz; // Leading one lands in bit 24.
	assign exp_n = 10'(s2_exp) + 10'd1 - 10'(lz);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result <= '0;
		end else if (s2_sum == 25'd0) begin
			result <= '0; // Exact cancellation.
		end else if (exp_n <= 10'sd0) begin
			result <= '{sign: s2_sign, exp: 8'd0, frac: 23'd0};
		end else if (exp_n >= 10'sd255) begin
			result <= '{sign: s2_sign, exp: 8'hff, frac: 23'd0};
		end else begin
			result <= '{sign: s2_sign, exp: exp_n[7:0], frac: norm[23:1]};
		end
	end

	// No denormal ever leaves the adder.
	a_no_denormal : assert property (@(posedge clk) disable iff (!rst_n)
		(result.exp == 8'd0) |-> (result.frac == 23'd0))
		else $error("fp_add produced a denormal result");

endmodule : fp_add

/* source/fp_mul.sv */
// Two-stage single precision multiplier, truncating, denormals flushed to zero.

`timescale 1ns/1ps

module fp_mul import ray_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  float_t a,
	input  float_t b,
	output float_t result
);

	logic               in_zero;
	logic [47:0]        prod;
	logic signed [9:0]  exp_sum;

	logic               s1_sign;
	logic               s1_zero;
	logic signed [9:0]  s1_exp;
	logic [47:0]        s1_prod;

	logic [22:0]        mant_n;
	logic signed [9:0]  exp_n;

	assign in_zero = (a.exp == 8'd0) || (b.exp == 8'd0);
	assign prod    = 48'({1'b1, a.frac}) * 48'({1'b1, b.frac});
	assign exp_sum = 10'(a.exp) + 10'(b.exp) - 10'd127; // Remove one bias.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_sign <= 1'b0;
			s1_zero <= 1'b1;
			s1_exp  <= '0;
			s1_prod <= '0;
		end else begin
			s1_sign <= a.sign ^ b.sign;
			s1_zero <= in_zero;
			s1_exp  <= exp_sum;
			s1_prod <= prod;
		end
	end

	// Product of two 1.x values lies in [1, 4), so one place at most.
	assign mant_n = s1_prod[47] ? s1_prod[46:24] : s1_prod[45:23];
	assign exp_n  = s1_prod[47] ? s1_exp + 10'sd1 : s1_exp;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result <= '0;
		end else if (s1_zero || exp_n <= 10'sd0) begin
			result <= '{sign: s1_sign, exp: 8'd0, frac: 23'd0}; // Zero or underflow.
		end else if (exp_n >= 10'sd255) begin
			result <= '{sign: s1_sign, exp: 8'hff, frac: 23'd0}; // Overflow.
		end else begin
			result <= '{sign: s1_sign, exp: exp_n[7:0], frac: mant_n};
		end
	end

endmodule : fp_mul

/* source/pcalc.sv */
// Hit-point datapath: operand registers, axis muxes, multiply-add, position registers.

`timescale 1ns/1ps

module pcalc import ray_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  ray_vec_t vec,
	input  float_t   t,
	pcalc_ctrl_if.dp ctrl,
	output vector_t  pos
);

	vector_t dir_q;
	vector_t org_q;
	float_t  t_q;
	float_t  dir_sel;
	float_t  org_sel;
	float_t  product;
	float_t  org_dly;
	float_t  sum;
	vector_t pos_q;

	always_ff @(posedge clk) begin
		if (ctrl.load) begin
			dir_q <= vec.dir;
			org_q <= vec.origin;
			t_q   <= t;
		end
	end

	always_comb begin
		case (ctrl.axis_sel)
			AXIS_X:  begin dir_sel = dir_q.x; org_sel = org_q.x; end
			AXIS_Y:  begin dir_sel = dir_q.y; org_sel = org_q.y; end
			default: begin dir_sel = dir_q.z; org_sel = org_q.z; end
		endcase
	end

	fp_mul i_mul (.clk, .rst_n, .a(dir_sel), .b(t_q), .result(product));

	// Origin waits out the multiplier.
	data_delay #(.DEPTH(MUL_LATENCY)) i_org_delay (
		.clk, .rst_n, .data_in(org_sel), .data_out(org_dly)
	);

	fp_add i_add (.clk, .rst_n, .a(product), .b(org_dly), .result(sum));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pos_q <= '0;
		end else begin
			if (ctrl.cap_x) pos_q.x <= sum;
			if (ctrl.cap_y) pos_q.y <= sum;
			if (ctrl.cap_z) pos_q.z <= sum;
		end
	end

	assign pos = pos_q;

	a_one_capture : assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({ctrl.cap_x, ctrl.cap_y, ctrl.cap_z}))
		else $error("more than one capture strobe active");

endmodule : pcalc

/* source/pcalc_ctrl.sv */
// Issue sequencer: three axis slots per ray, capture token pipe and done.

`timescale 1ns/1ps

module pcalc_ctrl import ray_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start,
	output logic       busy,
	output logic       done,
	pcalc_ctrl_if.ctrl ctrl
);

	logic       active;
	axis_e      axis_q;
	logic       accept;
	logic [2:0] token;
	logic [2:0] cap_sr [MUL_LATENCY + ADD_LATENCY];

	// A start in the z slot is taken, so rays can issue back to back.
	assign busy   = active && (axis_q != AXIS_Z);
	assign accept = start && !busy;
	assign token  = {axis_q == AXIS_Z, axis_q == AXIS_Y, axis_q == AXIS_X} & {3{active}};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active <= 1'b0;
			axis_q <= AXIS_X;
		end else if (accept) begin
			active <= 1'b1;
			axis_q <= AXIS_X;
		end else if (active) begin
			case (axis_q)
				AXIS_X:  axis_q <= AXIS_Y;
				AXIS_Y:  axis_q <= AXIS_Z;
				default: active <= 1'b0; // Last slot issued.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < MUL_LATENCY + ADD_LATENCY; i++) begin
				cap_sr[i] <= '0;
			end
			done <= 1'b0;
		end else begin
			cap_sr[0] <= token;
			for (int i = 1; i < MUL_LATENCY + ADD_LATENCY; i++) begin
				cap_sr[i] <= cap_sr[i-1];
			end
			done <= cap_sr[MUL_LATENCY + ADD_LATENCY - 1][2];
		end
	end

	assign ctrl.load     = accept;
	assign ctrl.axis_sel = axis_q;
	assign ctrl.cap_x    = cap_sr[MUL_LATENCY + ADD_LATENCY - 1][0];
	assign ctrl.cap_y    = cap_sr[MUL_LATENCY + ADD_LATENCY - 1][1];
	assign ctrl.cap_z    = cap_sr[MUL_LATENCY + ADD_LATENCY - 1][2];

	a_start_ignored : assert property (@(posedge clk) disable iff (!rst_n)
		!(start && busy))
		else $warning("start ignored while busy");

	a_done_pulse : assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else $error("done high for more than one cycle");

	a_done_latency : assert property (@(posedge clk) disable iff (!rst_n)
		accept |-> ##POS_LATENCY done)
		else $error("done missing after accepted start");

endmodule : pcalc_ctrl

/* source/pcalc_ctrl_if.sv */
// Control-to-datapath interface: operand load, axis select and capture strobes.

`timescale 1ns/1ps

interface pcalc_ctrl_if import ray_pkg::*; ();

	logic  load;     // Latch ray and t.
	axis_e axis_sel; // Axis being issued.
	logic  cap_x;
	logic  cap_y;
	logic  cap_z;

	modport ctrl (
		output load,
		output axis_sel,
		output cap_x,
		output cap_y,
		output cap_z
	);

	modport dp (
		input load,
		input axis_sel,
		input cap_x,
		input cap_y,
		input cap_z
	);

endinterface : pcalc_ctrl_if

/* source/ray_hit_pos.sv */
// Top level: ray hit position unit, control and datapath joined by the control bus.

`timescale 1ns/1ps

module ray_hit_pos import ray_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     start,
	input  ray_vec_t ray,
	input  float_t   t,
	output logic     busy,
	output logic     done,
	output vector_t  pos
);

	pcalc_ctrl_if ctrl_bus ();

	pcalc_ctrl i_ctrl (
		.clk,
		.rst_n,
		.start,
		.busy,
		.done,
		.ctrl (ctrl_bus.ctrl)
	);

	pcalc i_pcalc (
		.clk,
		.rst_n,
		.vec  (ray),
		.t,
		.ctrl (ctrl_bus.dp),
		.pos
	);

endmodule : ray_hit_pos

/* source/ray_pkg.sv */
// Float, vector, ray and axis types, and the pipeline latency constants.

package ray_pkg;

	// IEEE single precision bit pattern.
	typedef struct packed {
		logic        sign;
		logic [7:0]  exp;
		logic [22:0] frac;
	} float_t;

	typedef struct packed {
		float_t x;
		float_t y;
		float_t z;
	} vector_t;

	typedef struct packed {
		vector_t origin;
		vector_t dir;
	} ray_vec_t;

	// Axis entering the multiplier in the current issue slot.
	typedef enum logic [1:0] {
		AXIS_X,
		AXIS_Y,
		AXIS_Z
	} axis_e;

	localparam int MUL_LATENCY = 2; // fp_mul stages.
	localparam int ADD_LATENCY = 3; // fp_add stages.

	// Start sample to done seen high; load, z slot offset, mul, add, capture.
	localparam int POS_LATENCY = 1 + 2 + MUL_LATENCY + ADD_LATENCY + 1;

endpackage : ray_pkg

/* testbench/ray_hit_pos_vectors.svh */
// Stimulus table of rays, t values, expected hit positions and issue gaps.
`ifndef RAY_HIT_POS_VECTORS_SVH
`define RAY_HIT_POS_VECTORS_SVH

// Columns: ray {origin x y z, dir x y z}, t, expected pos {x y z},
// idle cycles before start, random extra gap allowed, start held into busy.
localparam int NUM_VECTORS = 13;

vec_entry_t vec_table [NUM_VECTORS] = '{
	'{ray: {32'h3f800000, 32'h40000000, 32'h40400000,
	        32'h3f800000, 32'h3f800000, 32'h3f800000}, t: 32'h40000000,
	  pos: {32'h40400000, 32'h40800000, 32'h40a00000}, gap: 0, rnd: 1'b0, dup: 1'b0},
	'{ray: {32'h00000000, 32'h00000000, 32'h00000000,
	        32'h3f800000, 32'hc0000000, 32'h3f000000}, t: 32'h40800000,
	  pos: {32'h40800000, 32'hc1000000, 32'h40000000}, gap: 4, rnd: 1'b0, dup: 1'b0},
	// Negative origin and direction, fractional t.
	'{ray: {32'hc0400000, 32'h3fc00000, 32'hbf800000,
	        32'hbf800000, 32'h40000000, 32'h3e800000}, t: 32'h3f000000,
	  pos: {32'hc0600000, 32'h40200000, 32'hbf600000}, gap: 2, rnd: 1'b0, dup: 1'b0},
	// t of zero leaves the origin.
	'{ray: {32'h40a00000, 32'hc0000000, 32'h40e00000,
	        32'hc0400000, 32'h40800000, 32'hbf800000}, t: 32'h00000000,
	  pos: {32'h40a00000, 32'hc0000000, 32'h40e00000}, gap: 1, rnd: 1'b1, dup: 1'b0},
	// Exact cancellation on x and y.
	'{ray: {32'h40800000, 32'hc0c00000, 32'h40000000,
	        32'hc0000000, 32'h40400000, 32'h3f800000}, t: 32'h40000000,
	  pos: {32'h00000000, 32'h00000000, 32'h40800000}, gap: 12, rnd: 1'b0, dup: 1'b0},
	// Large exponent gaps between origin and product.
	'{ray: {32'h44800000, 32'hc4800000, 32'h44800000,
	        32'h3f000000, 32'h3f800000, 32'hbe000000}, t: 32'h3f000000,
	  pos: {32'h44800800, 32'hc47fe000, 32'h447ffc00}, gap: 2, rnd: 1'b0, dup: 1'b0},
	// Three rays back to back.
	'{ray: {32'h3f800000, 32'h3f800000, 32'h3f800000,
	        32'h40000000, 32'h40400000, 32'h40800000}, t: 32'h3f800000,
	  pos: {32'h40400000, 32'h40800000, 32'h40a00000}, gap: 10, rnd: 1'b0, dup: 1'b0},
	'{ray: {32'hbf800000, 32'hc0000000, 32'hc0800000,
	        32'h3f800000, 32'h3f800000, 32'h3f800000}, t: 32'h40400000,
	  pos: {32'h40000000, 32'h3f800000, 32'hbf800000}, gap: 0, rnd: 1'b0, dup: 1'b0},
	'{ray: {32'h41000000, 32'h41800000, 32'h3e800000,
	        32'hbf800000, 32'hc0000000, 32'hbf000000}, t: 32'h40800000,
	  pos: {32'h40800000, 32'h41000000, 32'hbfe00000}, gap: 0, rnd: 1'b0, dup: 1'b0},
	// Start held one more cycle while busy.
	'{ray: {32'h40000000, 32'h40000000, 32'h40000000,
	        32'h3f800000, 32'hbf800000, 32'h3f000000}, t: 32'h40000000,
	  pos: {32'h40800000, 32'h00000000, 32'h40400000}, gap: 3, rnd: 1'b0, dup: 1'b1},
	'{ray: {32'h3f000000, 32'hbf000000, 32'h41200000,
	        32'h3f000000, 32'h3f000000, 32'hbf800000}, t: 32'h3f800000,
	  pos: {32'h3f800000, 32'h00000000, 32'h41100000}, gap: 0, rnd: 1'b0, dup: 1'b0},
	'{ray: {32'h40c00000, 32'hc0e00000, 32'h41400000,
	        32'h3fc00000, 32'hbf800000, 32'h3e800000}, t: 32'h40000000,
	  pos: {32'h41100000, 32'hc1100000, 32'h41480000}, gap: 1, rnd: 1'b1, dup: 1'b0},
	'{ray: {32'hc1000000, 32'h40400000, 32'hbf000000,
	        32'hc0000000, 32'h3f400000, 32'h3f800000}, t: 32'hc0000000,
	  pos: {32'hc0800000, 32'h3fc00000, 32'hc0200000}, gap: 0, rnd: 1'b1, dup: 1'b0}
};

`endif

/* testbench/ray_hit_pos_tb.sv */
// Testbench for ray_hit_pos: table driver, done monitor, compare tasks and timeout.

`timescale 1ns/1ps

module ray_hit_pos_tb import ray_pkg::*; ();

	localparam int          RESET_CYCLES  = 2;
	localparam int          MAX_EXTRA_GAP = 2;
	localparam int unsigned RAND_SEED     = 32'h0a26d3fa;

	typedef struct packed {
		ray_vec_t ray;
		float_t   t;
		vector_t  pos;
		int       gap; // Idle cycles before start.
		bit       rnd; // Random extra gap allowed.
		bit       dup; // Start held into the busy cycle.
	} vec_entry_t;

	typedef struct {
		vector_t pos;
		int      done_edge;
	} expect_t;

	`include "ray_hit_pos_vectors.svh"

	logic     clk;
	logic     rst_n;
	logic     start;
	ray_vec_t ray;
	float_t   t;
	logic     busy;
	logic     done;
	vector_t  pos;

	int      cycle;
	int      timeout_limit;
	int      errors;
	int      accept_count;
	int      done_count;
	expect_t expect_q [$];

	ray_hit_pos i_dut (
		.clk,
		.rst_n,
		.start,
		.ray,
		.t,
		.busy,
		.done,
		.pos
	);

	always #10 clk = ~clk;

	task automatic check_float(input string name, input float_t got, input float_t want);
		if (got !== want) begin
			errors++;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic check_vector(input string name, input vector_t got, input vector_t want);
		check_float({name, ".x"}, got.x, want.x);
		check_float({name, ".y"}, got.y, want.y);
		check_float({name, ".z"}, got.z, want.z);
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			errors++;
			$display("error at %0t: %s is %b, expected %b", $time, name, got, want);
		end
	endtask

	task automatic check_count(input string name, input int got, input int want);
		if (got != want) begin
			errors++;
			$display("error at %0t: %s is %0d, expected %0d", $time, name, got, want);
		end
	endtask

	// Holds start until the DUT takes it, then queues the expected result.
	task automatic drive_ray(input int idx);
		vec_entry_t e;
		int         idle;
		expect_t    item;
		e    = vec_table[idx];
		idle = e.gap;
		if (e.rnd)
			idle = idle + int'($urandom % (MAX_EXTRA_GAP + 1));
		repeat (idle) @(posedge clk);
		@(posedge clk);
		start <= 1'b1;
		ray   <= e.ray;
		t     <= e.t;
		@(negedge clk);
		while (busy) begin
			@(posedge clk);
			@(negedge clk);
		end
		item.pos       = e.pos;
		item.done_edge = cycle + 1 + POS_LATENCY; // Next edge samples start.
		expect_q.push_back(item);
		accept_count++;
		@(posedge clk);
		if (e.dup) begin
			ray <= ~e.ray; // Must not reach the ray in flight.
			t   <= ~e.t;
		end else begin
			start <= 1'b0;
		end
		@(negedge clk);
		check_bit("busy", busy, 1'b1);
		if (e.dup) begin
			@(posedge clk);
			start <= 1'b0;
		end
	endtask

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= timeout_limit) begin
			$display("Timeout: run did not finish within %0d cycles", timeout_limit);
			$display("Verification failed");
			$finish;
		end
	end

	always @(negedge clk) begin
		expect_t item;
		if (rst_n && done) begin
			done_count++;
			if (expect_q.size() == 0) begin
				errors++;
				$display("Done pulse at %0t with no ray in flight", $time);
			end else begin
				item = expect_q.pop_front();
				check_count("done edge", cycle + 1, item.done_edge);
				check_vector("pos", pos, item.pos);
			end
		end
	end

	initial begin
		int max_gap;
		clk          = 1'b0;
		rst_n        = 1'b0;
		start        = 1'b0;
		ray          = '0;
		t            = '0;
		cycle        = 0;
		errors       = 0;
		accept_count = 0;
		done_count   = 0;
		void'($urandom(RAND_SEED));
		max_gap      = 0;
		foreach (vec_table[i]) begin
			if (vec_table[i].gap > max_gap)
				max_gap = vec_table[i].gap;
		end
		timeout_limit = NUM_VECTORS * (4 + max_gap + MAX_EXTRA_GAP)
			+ 2 * POS_LATENCY + 20 + RESET_CYCLES;

		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_bit("busy", busy, 1'b0);
		check_bit("done", done, 1'b0);
		check_vector("pos", pos, '0);

		for (int i = 0; i < NUM_VECTORS; i++)
			drive_ray(i);
		while (expect_q.size() != 0)
			@(negedge clk);
		repeat (POS_LATENCY) @(negedge clk); // Catch any stray done.
		check_count("done pulses", done_count, accept_count);

		$display("Errors: %0d, rays accepted: %0d, done pulses: %0d",
			errors, accept_count, done_count);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule : ray_hit_pos_tb
